// File: project.f
source/sem_cfg_pkg.sv
source/sem_bus_pkg.sv
source/sem_fifo.sv
source/sem_cmd_seq.sv
source/sem_ecc_tracker.sv
source/sem_wb_regs.sv
source/sem_monitor_top.sv
testbench/sem_monitor_chk.sv
testbench/sem_monitor_tb.sv

// File: Makefile
SIM      = verilator
TOP      = sem_monitor_tb
FILELIST = project.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

# status comes from the grep, the output is echoed first
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)

// File: testbench/sem_monitor_tb.sv
// testbench for the SEM monitor subsystem
module sem_monitor_tb
	import sem_bus_pkg::*;
;
	localparam int TX_DEPTH = 16;
	localparam int EV_DEPTH = 4;
	localparam int k_wr = 0, k_rd = 1, k_status = 2, k_ecc = 3, k_push = 4, k_rxread = 5;
	localparam int k_pins = 6;	// rxempty, txfull, rxdata

	typedef struct {
		int          kind;
		int          test;
		logic [3:0]  adr;
		logic [63:0] data;	// ecc packs far, word, bit, err, single, crc, pulse from bit 0 up
		logic [31:0] exp;
		logic [31:0] mask;
	} step_t;

	logic CLK40, arst_n_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
	logic [3:0] wb_adr_i;
	logic [31:0] wb_dat_i, wb_dat_o;
	logic [7:0] status_i, monitor_txdata_i, monitor_rxdata_o;
	logic fecc_crcerr_i, fecc_eccerr_i, fecc_eccsingle_i, fecc_synvalid_i;
	logic [23:0] fecc_far_i;
	logic [6:0] fecc_synword_i;
	logic [4:0] fecc_synbit_i;
	logic monitor_txwrite_i, monitor_txfull_o, monitor_rxread_i, monitor_rxempty_o;

	step_t steps[$];
	string test_name[5];
	int cur_test, fail_cnt, checks, tests_failed;
	logic [31:0] rng;

	// reference model state
	logic m_hold, m_err, m_single, m_in_err, m_in_single, m_in_crc, m_ovf, m_busy;
	logic [7:0] m_status, m_scnt, m_mcnt, m_rxbyte;
	logic [7:0] m_tx[$];
	logic [23:0] m_evfar[$];
	logic [11:0] m_evsyn[$];	// synbit above synword

	sem_monitor_top #(.TX_DEPTH(TX_DEPTH), .EV_DEPTH(EV_DEPTH)) sem_monitor_top_inst (.*);

	initial
	begin
		CLK40 = 1'b0;
		forever #2 CLK40 = ~CLK40;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// model and table building
	////////////////////////////////////////////////////////////////////////////

	// every flag rule is idempotent, so one update per step is enough
	function automatic void update_flags();
		if (!m_hold || m_status[4])
		begin
			m_err    = m_in_err;	// follow or classification reload
			m_single = m_in_single;
		end
		else if (m_status[3])
		begin
			m_err    = m_err & m_in_crc;
			m_single = m_single & m_in_crc;
		end
		else
		begin
			m_err    = m_err | m_in_err;	// sticky
			m_single = m_single | m_in_single;
		end
	endfunction

	function automatic void add_step(int kind, logic [3:0] adr, logic [63:0] data,
		logic [31:0] exp, logic [31:0] mask);
		step_t st;
		st = '{kind, cur_test, adr, data, exp, mask};
		steps.push_back(st);
		update_flags();
	endfunction

	function automatic void add_wr(logic [3:0] adr, logic [31:0] data);
		if (adr == reg_ctrl)
			m_hold = data[0];
		if (adr == reg_cmd && !m_busy)
		begin
			m_busy   = 1'b1;
			m_rxbyte = data[7:0];
		end
		if (adr == reg_clear)
		begin
			m_scnt = '0;
			m_mcnt = '0;
			m_ovf  = 1'b0;
		end
		add_step(k_wr, adr, {32'd0, data}, '0, '0);
	endfunction

	function automatic void add_rd(logic [3:0] adr);
		logic [31:0] exp;
		logic [31:0] mask;
		exp  = '0;
		mask = '1;
		case (adr)
			reg_status: exp = {18'd0, m_ovf, m_evfar.size() == 0, m_tx.size() == 0, m_busy,
				m_single, m_err, m_status};
			reg_ctrl:   exp = {31'd0, m_hold};
			reg_txdata:
				if (m_tx.size() != 0)
					exp = {23'd0, 1'b1, m_tx.pop_front()};
				else
					mask = 32'hffff_ff00;	// valid 0 over a stale head byte
			reg_counts: exp = {16'd0, m_mcnt, m_scnt};
			reg_evfar:
				if (m_evfar.size() != 0)
					exp = {8'd0, m_evfar[0]};
				else
					mask = '0;	// head data undefined when empty
			reg_evsyn:
				if (m_evsyn.size() != 0)
				begin
					exp = {1'b1, 19'd0, m_evsyn.pop_front()};
					void'(m_evfar.pop_front());
				end
				else
					mask = 32'h8000_0000;	// stale head data
			default:    exp = '0;
		endcase
		add_step(k_rd, adr, '0, exp, mask);
	endfunction

	function automatic void add_ecc(logic err, logic single, logic crc, logic pulse);
		logic [23:0] far;
		logic [11:0] syn;
		far = next_random() >> 8;
		syn = next_random() >> 20;
		m_in_err    = err;
		m_in_single = single;
		m_in_crc    = crc;
		if (pulse)
		begin
			if (m_evfar.size() == EV_DEPTH)
				m_ovf = 1'b1;	// dropped
			else
			begin
				m_evfar.push_back(far);
				m_evsyn.push_back(syn);
			end
			if (err && single && m_scnt != 8'hff)
				m_scnt++;
			if (err && !single && m_mcnt != 8'hff)
				m_mcnt++;
		end
		add_step(k_ecc, '0, {24'd0, pulse, crc, single, err, syn, far}, '0, '0);
	endfunction

	function automatic void add_push();
		logic [7:0] b;
		b = next_random() >> 24;
		if (m_tx.size() < TX_DEPTH)
			m_tx.push_back(b);
		add_step(k_push, '0, {56'd0, b}, '0, '0);
	endfunction

	function automatic void add_pins();
		add_step(k_pins, '0, '0, {22'd0, !m_busy, m_tx.size() == TX_DEPTH, m_rxbyte},
			m_busy ? 32'h3ff : 32'h300);
	endfunction

	function automatic void build_table();
		cur_test = 0;	// reset and registers
		add_rd(reg_status);
		add_rd(reg_counts);
		add_rd(reg_ctrl);
		add_wr(reg_ctrl, 1);
		add_rd(reg_ctrl);
		add_wr(reg_ctrl, 0);
		add_rd(reg_ctrl);
		cur_test = 1;	// flag tracking
		add_ecc(1, 1, 0, 0);
		add_rd(reg_status);
		add_ecc(0, 0, 0, 0);
		add_rd(reg_status);
		add_wr(reg_ctrl, 1);
		add_ecc(1, 1, 0, 0);
		add_ecc(0, 0, 0, 0);
		add_rd(reg_status);
		add_step(k_status, '0, 64'h10, '0, '0);
		m_status = 8'h10;	// classification
		update_flags();
		add_rd(reg_status);
		add_step(k_status, '0, 64'h00, '0, '0);
		m_status = 8'h00;
		update_flags();
		add_ecc(1, 0, 0, 0);
		add_ecc(0, 0, 0, 0);
		add_rd(reg_status);
		add_step(k_status, '0, 64'h08, '0, '0);
		m_status = 8'h08;	// correction
		update_flags();
		add_rd(reg_status);
		add_step(k_status, '0, 64'h00, '0, '0);
		m_status = 8'h00;
		update_flags();
		add_wr(reg_ctrl, 0);
		cur_test = 2;	// counting and events
		add_ecc(1, 1, 0, 1);
		add_ecc(1, 0, 0, 1);
		add_ecc(0, 0, 0, 1);
		add_rd(reg_counts);
		repeat (4)
		begin
			add_rd(reg_evfar);
			add_rd(reg_evsyn);
		end
		repeat (EV_DEPTH + 1) add_ecc(1, 1, 0, 1);
		add_ecc(0, 0, 0, 0);
		add_rd(reg_status);
		add_rd(reg_counts);
		add_wr(reg_clear, 32'h5a);
		add_rd(reg_counts);
		add_rd(reg_status);
		repeat (EV_DEPTH)
		begin
			add_rd(reg_evfar);
			add_rd(reg_evsyn);
		end
		cur_test = 3;	// monitor bytes
		repeat (TX_DEPTH) add_push();
		add_pins();
		add_push();
		add_pins();
		repeat (TX_DEPTH + 1) add_rd(reg_txdata);
		add_pins();
		cur_test = 4;	// commands
		add_pins();
		add_wr(reg_cmd, next_random());
		add_pins();
		add_wr(reg_cmd, next_random());
		add_pins();
		add_rd(reg_status);
		add_step(k_rxread, '0, '0, '0, '0);
		m_busy = 1'b0;
		add_pins();
		add_rd(reg_status);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// drivers and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp,
		logic [31:0] mask);
		if (mask != 0)
		begin
			checks++;
			assert (((got ^ exp) & mask) == 0)
			else
			begin
				$display("Mismatch %s: got %h, expected %h", name, got & mask, exp & mask);
				fail_cnt++;
			end
		end
	endtask

	// already on a rising edge when called
	task automatic wb_access(step_t s);
		int waited;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= (s.kind == k_wr);
		wb_adr_i <= s.adr;
		wb_dat_i <= s.data[31:0];
		waited = 0;
		do
		begin
			@(negedge CLK40);	// ack stable here
			waited++;
		end
		while (!wb_ack_o && waited < 10);
		// first negedge sees stb alone, ack belongs on the second
		assert (wb_ack_o && waited == 2)
		else
		begin
			$display("ack on address %0d not seen one cycle after stb (waited %0d cycles)",
				s.adr, waited - 1);
			fail_cnt++;
		end
		if (s.kind == k_rd)
			compare_value($sformatf("wb_dat_o at address %0d", s.adr), wb_dat_o, s.exp, s.mask);
		@(posedge CLK40);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic apply_step(step_t s);
		@(posedge CLK40);
		case (s.kind)
			k_wr, k_rd: wb_access(s);
			k_status:
			begin
				status_i <= s.data[7:0];
				@(posedge CLK40);
			end
			k_ecc:
			begin
				{fecc_crcerr_i, fecc_eccsingle_i, fecc_eccerr_i} <= s.data[38:36];
				{fecc_synbit_i, fecc_synword_i, fecc_far_i} <= s.data[35:0];
				fecc_synvalid_i <= s.data[39];
				@(posedge CLK40);
				fecc_synvalid_i <= 1'b0;	// one cycle pulse
			end
			k_push, k_rxread:
			begin
				monitor_txwrite_i <= (s.kind == k_push);
				monitor_txdata_i  <= s.data[7:0];
				monitor_rxread_i  <= (s.kind == k_rxread);
				@(posedge CLK40);
				monitor_txwrite_i <= 1'b0;
				monitor_rxread_i  <= 1'b0;
			end
			default:
			begin
				@(negedge CLK40);
				compare_value("monitor_rxempty_o", 32'(monitor_rxempty_o), s.exp >> 9, 1);
				compare_value("monitor_txfull_o", 32'(monitor_txfull_o), s.exp >> 8, 1);
				compare_value("monitor_rxdata_o", 32'(monitor_rxdata_o), s.exp, s.mask & 8'hff);
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int errs_before;
		test_name = '{"reset and registers", "ecc flags", "counters and events",
			"monitor bytes", "commands"};
		{arst_n_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i, status_i} = '0;
		{fecc_crcerr_i, fecc_eccerr_i, fecc_eccsingle_i, fecc_synvalid_i} = '0;
		{fecc_far_i, fecc_synword_i, fecc_synbit_i} = '0;
		{monitor_txdata_i, monitor_txwrite_i, monitor_rxread_i} = '0;
		{m_hold, m_err, m_single, m_in_err, m_in_single, m_in_crc, m_ovf, m_busy} = '0;
		{m_status, m_scnt, m_mcnt, m_rxbyte} = '0;
		{fail_cnt, checks, tests_failed, errs_before} = '0;
		rng = 32'h87a3c7eb;
		build_table();
		repeat (3) @(posedge CLK40);
		arst_n_i <= 1'b1;
		foreach (steps[i])
		begin
			apply_step(steps[i]);
			if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test)
			begin
				if (fail_cnt == errs_before)
					$display("test %0d %s: ok", steps[i].test, test_name[steps[i].test]);
				else
				begin
					$display("test %0d %s: failed with %0d errors", steps[i].test,
						test_name[steps[i].test], fail_cnt - errs_before);
					tests_failed++;
				end
				errs_before = fail_cnt;
			end
		end
		$display("tests 5, failed %0d, checks %0d, errors %0d", tests_failed, checks, fail_cnt);
		if (fail_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// 40 cycles per step once the table is built at time 0
	initial
	begin
		#1;
		repeat (steps.size() * 40 + 10) @(posedge CLK40);
		$display("watchdog expired before the step table finished");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: testbench/sem_monitor_chk.sv
// handshake checks, bound into the monitor top
module sem_monitor_chk (
	input logic CLK40,
	input logic arst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_o,
	input logic monitor_rxempty_o,
	input logic monitor_rxread_i
);

	////////////////////////////////////////////////////////////////////////////
	// Wishbone
	////////////////////////////////////////////////////////////////////////////

	// ack only answers a request seen the cycle before
	ack_follows_req: assert property (@(posedge CLK40) disable iff (!arst_n_i)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
		else $error("ack without a preceding cyc and stb");

	ack_one_cycle: assert property (@(posedge CLK40) disable iff (!arst_n_i)
		wb_ack_o |=> !wb_ack_o)	// never two in a row
		else $error("ack held for two cycles");

	////////////////////////////////////////////////////////////////////////////
	// command handshake
	////////////////////////////////////////////////////////////////////////////

	rxempty_in_reset: assert property (@(posedge CLK40)
		!arst_n_i |-> monitor_rxempty_o)
		else $error("rxempty low during reset");

	// core read frees the held byte
	rxread_frees: assert property (@(posedge CLK40) disable iff (!arst_n_i)
		(monitor_rxread_i && !monitor_rxempty_o) |=> monitor_rxempty_o)
		else $error("rxempty still low after rxread");

endmodule

bind sem_monitor_top sem_monitor_chk sem_monitor_chk_inst (
	.CLK40(CLK40), .arst_n_i(arst_n_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
	.wb_ack_o(wb_ack_o), .monitor_rxempty_o(monitor_rxempty_o),
	.monitor_rxread_i(monitor_rxread_i));

// File: source/sem_monitor_top.sv
// SEM monitor subsystem top
module sem_monitor_top
	import sem_cfg_pkg::*, sem_bus_pkg::*;
#(
	parameter int TX_DEPTH = 16,	// monitor bytes
	parameter int EV_DEPTH = 4		// syndrome events
) (
	input  logic                     CLK40,
	input  logic                     arst_n_i,
	// Wishbone
	input  logic                     wb_cyc_i,
	input  logic                     wb_stb_i,
	input  logic                     wb_we_i,
	input  logic [wb_adr_w-1:0]      wb_adr_i,
	input  logic [wb_dat_w-1:0]      wb_dat_i,
	output logic [wb_dat_w-1:0]      wb_dat_o,
	output logic                     wb_ack_o,
	// SEM core and frame ECC
	input  logic [7:0]               status_i,
	input  logic                     fecc_crcerr_i,
	input  logic                     fecc_eccerr_i,
	input  logic                     fecc_eccsingle_i,
	input  logic                     fecc_synvalid_i,
	input  logic [sem_far_w-1:0]     fecc_far_i,
	input  logic [sem_synword_w-1:0] fecc_synword_i,
	input  logic [sem_synbit_w-1:0]  fecc_synbit_i,
	input  logic [7:0]               monitor_txdata_i,
	input  logic                     monitor_txwrite_i,
	output logic                     monitor_txfull_o,
	output logic [7:0]               monitor_rxdata_o,
	input  logic                     monitor_rxread_i,
	output logic                     monitor_rxempty_o
);

	logic                 hold_en, clear;
	logic                 ecc_err, ecc_single;
	logic [sem_cnt_w-1:0] single_cnt, multi_cnt;
	logic                 cmd_wr, cmd_busy;
	logic [7:0]           cmd_data;
	logic                 tx_pop, tx_empty;
	logic [7:0]           tx_head;
	logic                 ev_push, ev_pop, ev_empty, ev_full, ev_overflow;
	sem_ecc_event_t       ev_data, ev_head;

	sem_wb_regs sem_wb_regs_inst (
		.CLK40, .arst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
		.wb_dat_o, .wb_ack_o, .status_i, .ecc_err_i(ecc_err), .ecc_single_i(ecc_single),
		.single_cnt_i(single_cnt), .multi_cnt_i(multi_cnt), .ev_overflow_i(ev_overflow),
		.cmd_busy_i(cmd_busy), .tx_empty_i(tx_empty), .tx_data_i(tx_head), .tx_pop_o(tx_pop),
		.ev_empty_i(ev_empty), .ev_head_i(ev_head), .ev_pop_o(ev_pop), .hold_en_o(hold_en),
		.clear_o(clear), .cmd_wr_o(cmd_wr), .cmd_data_o(cmd_data));

	sem_ecc_tracker sem_ecc_tracker_inst (
		.CLK40, .arst_n_i, .hold_en_i(hold_en), .clear_i(clear), .status_i,
		.fecc_crcerr_i, .fecc_eccerr_i, .fecc_eccsingle_i, .fecc_synvalid_i,
		.fecc_far_i, .fecc_synword_i, .fecc_synbit_i, .ecc_err_o(ecc_err),
		.ecc_single_o(ecc_single), .single_cnt_o(single_cnt), .multi_cnt_o(multi_cnt),
		.ev_push_o(ev_push), .ev_data_o(ev_data), .ev_full_i(ev_full),
		.ev_overflow_o(ev_overflow));

	sem_cmd_seq sem_cmd_seq_inst (
		.CLK40, .arst_n_i, .cmd_wr_i(cmd_wr), .cmd_data_i(cmd_data), .cmd_busy_o(cmd_busy),
		.monitor_rxdata_o, .monitor_rxempty_o, .monitor_rxread_i);

	// core monitor bytes, core pushes directly
	sem_fifo #(.payload_t(logic [7:0]), .DEPTH(TX_DEPTH)) tx_fifo_inst (
		.CLK40, .arst_n_i, .push_i(monitor_txwrite_i), .push_data_i(monitor_txdata_i),
		.pop_i(tx_pop), .head_o(tx_head), .empty_o(tx_empty), .full_o(monitor_txfull_o));

	// syndrome event log
	sem_fifo #(.payload_t(sem_ecc_event_t), .DEPTH(EV_DEPTH)) ev_fifo_inst (
		.CLK40, .arst_n_i, .push_i(ev_push), .push_data_i(ev_data),
		.pop_i(ev_pop), .head_o(ev_head), .empty_o(ev_empty), .full_o(ev_full));

endmodule

// File: source/sem_wb_regs.sv
// Wishbone classic slave with the monitor register file
module sem_wb_regs
	import sem_cfg_pkg::*, sem_bus_pkg::*;
(
	input  logic                CLK40,
	input  logic                arst_n_i,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  logic [wb_adr_w-1:0] wb_adr_i,
	input  logic [wb_dat_w-1:0] wb_dat_i,
	output logic [wb_dat_w-1:0] wb_dat_o,
	output logic                wb_ack_o,
	input  logic [7:0]          status_i,	// core flags
	input  logic                ecc_err_i,
	input  logic                ecc_single_i,
	input  logic [sem_cnt_w-1:0] single_cnt_i,
	input  logic [sem_cnt_w-1:0] multi_cnt_i,
	input  logic                ev_overflow_i,
	input  logic                cmd_busy_i,
	input  logic                tx_empty_i,
	input  logic [7:0]          tx_data_i,	// tx FIFO head
	output logic                tx_pop_o,
	input  logic                ev_empty_i,
	input  sem_ecc_event_t      ev_head_i,	// event FIFO head
	output logic                ev_pop_o,
	output logic                hold_en_o,
	output logic                clear_o,
	output logic                cmd_wr_o,
	output logic [7:0]          cmd_data_o
);

	logic                req;		// new access, not yet acked
	logic                rd_req;
	logic                wr_req;
	sem_reg_e            adr;
	logic [wb_dat_w-1:0] rd_mux;

	assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;	// ~ack keeps ack to one cycle
	assign rd_req = req & ~wb_we_i;
	assign wr_req = req & wb_we_i;
	assign adr    = sem_reg_e'(wb_adr_i);

	////////////////////////////////////////////////////////////////////////////
	// read mux, unmapped and write-only addresses read 0
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		rd_mux = '0;
		case (adr)
			reg_status:
			begin
				rd_mux[7:0]            = status_i;
				rd_mux[st_eccerr_b]    = ecc_err_i;
				rd_mux[st_eccsingle_b] = ecc_single_i;
				rd_mux[st_cmdbusy_b]   = cmd_busy_i;
				rd_mux[st_txempty_b]   = tx_empty_i;
				rd_mux[st_evempty_b]   = ev_empty_i;
				rd_mux[st_evovf_b]     = ev_overflow_i;
			end
			reg_ctrl:   rd_mux[ctrl_hold_b] = hold_en_o;
			reg_txdata: rd_mux[txdata_valid_b:0] = {~tx_empty_i, tx_data_i};
			reg_counts:
			begin
				rd_mux[sem_cnt_w-1:0]                 = single_cnt_i;
				rd_mux[counts_multi_lsb +: sem_cnt_w] = multi_cnt_i;
			end
			reg_evfar:  rd_mux[sem_far_w-1:0] = ev_head_i.far;
			reg_evsyn:
			begin
				rd_mux[sem_synword_w-1:0]               = ev_head_i.synword;
				rd_mux[evsyn_bit_lsb +: sem_synbit_w]   = ev_head_i.synbit;
				rd_mux[evsyn_valid_b]                   = ~ev_empty_i;
			end
			default:    rd_mux = '0;
		endcase
	end

	// ack plus every strobe lands in the ack cycle
	always_ff @(posedge CLK40 or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wb_ack_o  <= 1'b0;
			tx_pop_o  <= 1'b0;
			ev_pop_o  <= 1'b0;
			clear_o   <= 1'b0;
			cmd_wr_o  <= 1'b0;
			hold_en_o <= 1'b0;
		end
		else
		begin
			wb_ack_o <= req;
			tx_pop_o <= rd_req & (adr == reg_txdata) & ~tx_empty_i;	// pop only what was read
			ev_pop_o <= rd_req & (adr == reg_evsyn) & ~ev_empty_i;
			clear_o  <= wr_req & (adr == reg_clear);	// any value
			cmd_wr_o <= wr_req & (adr == reg_cmd);
			if (wr_req && adr == reg_ctrl)
				hold_en_o <= wb_dat_i[ctrl_hold_b];
		end
	end

	// read data and command byte, valid with their strobes
	always_ff @(posedge CLK40)
	begin
		if (rd_req)
			wb_dat_o <= rd_mux;
		if (wr_req && adr == reg_cmd)
			cmd_data_o <= wb_dat_i[7:0];
	end

endmodule

// File: source/sem_ecc_tracker.sv
// frame ECC flag latching, error counters and syndrome event capture
module sem_ecc_tracker
	import sem_cfg_pkg::*;
(
	input  logic                     CLK40,
	input  logic                     arst_n_i,
	input  logic                     hold_en_i,		// CTRL hold mode
	input  logic                     clear_i,		// counters and overflow
	input  logic [7:0]               status_i,
	input  logic                     fecc_crcerr_i,
	input  logic                     fecc_eccerr_i,
	input  logic                     fecc_eccsingle_i,
	input  logic                     fecc_synvalid_i,
	input  logic [sem_far_w-1:0]     fecc_far_i,
	input  logic [sem_synword_w-1:0] fecc_synword_i,
	input  logic [sem_synbit_w-1:0]  fecc_synbit_i,
	output logic                     ecc_err_o,
	output logic                     ecc_single_o,
	output logic [sem_cnt_w-1:0]     single_cnt_o,
	output logic [sem_cnt_w-1:0]     multi_cnt_o,
	output logic                     ev_push_o,
	output sem_ecc_event_t           ev_data_o,
	input  logic                     ev_full_i,
	output logic                     ev_overflow_o	// sticky
);

	logic synvalid_q;	// for edge detect
	logic syn_rise;
	logic in_class;
	logic in_corr;

	assign in_class = status_i[sem_st_classification];
	assign in_corr  = status_i[sem_st_correction];

	////////////////////////////////////////////////////////////////////////////
	// ECC flags
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ecc_err_o    <= 1'b0;
			ecc_single_o <= 1'b0;
		end
		else if (!hold_en_i)
		begin
			ecc_err_o    <= fecc_eccerr_i;	// plain follow
			ecc_single_o <= fecc_eccsingle_i;
		end
		else if (in_class)
		begin
			// classification reloads from the primitive
			ecc_err_o    <= fecc_eccerr_i;
			ecc_single_o <= fecc_eccsingle_i;
		end
		else if (in_corr)
		begin
			ecc_err_o    <= ecc_err_o & fecc_crcerr_i;	// kept only while crc still bad
			ecc_single_o <= ecc_single_o & fecc_crcerr_i;
		end
		else
		begin
			ecc_err_o    <= ecc_err_o | fecc_eccerr_i;	// sticky
			ecc_single_o <= ecc_single_o | fecc_eccsingle_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// syndrome events and counters
	////////////////////////////////////////////////////////////////////////////

	assign syn_rise = fecc_synvalid_i & ~synvalid_q;

	// event goes straight into the FIFO on the rising edge
	assign ev_push_o         = syn_rise & ~ev_full_i;
	assign ev_data_o.far     = fecc_far_i;
	assign ev_data_o.synword = fecc_synword_i;
	assign ev_data_o.synbit  = fecc_synbit_i;

	always_ff @(posedge CLK40 or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			synvalid_q    <= 1'b0;
			single_cnt_o  <= '0;
			multi_cnt_o   <= '0;
			ev_overflow_o <= 1'b0;
		end
		else
		begin
			synvalid_q <= fecc_synvalid_i;
			if (clear_i)
			begin
				single_cnt_o  <= '0;
				multi_cnt_o   <= '0;
				ev_overflow_o <= 1'b0;
			end
			else if (syn_rise)
			begin
				if (ev_full_i)
					ev_overflow_o <= 1'b1;	// event lost
				// no eccerror, nothing counted
				if (fecc_eccerr_i && fecc_eccsingle_i && !(&single_cnt_o))
					single_cnt_o <= single_cnt_o + 1'b1;
				if (fecc_eccerr_i && !fecc_eccsingle_i && !(&multi_cnt_o))
					multi_cnt_o <= multi_cnt_o + 1'b1;
			end
		end
	end

endmodule

// File: source/sem_cmd_seq.sv
// holds one host command byte for the core's rx handshake
module sem_cmd_seq (
	input  logic       CLK40,
	input  logic       arst_n_i,
	input  logic       cmd_wr_i,		// acked CMD write
	input  logic [7:0] cmd_data_i,
	output logic       cmd_busy_o,
	output logic [7:0] monitor_rxdata_o,
	output logic       monitor_rxempty_o,
	input  logic       monitor_rxread_i	// core took the byte
);

	typedef enum logic {
		cs_idle,
		cs_held
	} cmd_state_e;

	cmd_state_e state;
	cmd_state_e state_nxt;

	////////////////////////////////////////////////////////////////////////////
	// two-state sequencer
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			cs_idle:
				if (cmd_wr_i)
					state_nxt = cs_held;
			cs_held:
				if (monitor_rxread_i)
					state_nxt = cs_idle;	// writes while held are ignored
			default:
				state_nxt = cs_idle;
		endcase
	end

	always_ff @(posedge CLK40 or negedge arst_n_i)
	begin
		if (!arst_n_i)
			state <= cs_idle;
		else
			state <= state_nxt;
	end

	// byte loaded only from idle
	always_ff @(posedge CLK40)
	begin
		if (state == cs_idle && cmd_wr_i)
			monitor_rxdata_o <= cmd_data_i;
	end

	assign cmd_busy_o        = (state == cs_held);
	assign monitor_rxempty_o = (state == cs_idle);	// high out of reset

endmodule

// File: source/sem_fifo.sv
// synchronous FIFO, payload given as a type
module sem_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 16		// power of two
) (
	input  logic     CLK40,
	input  logic     arst_n_i,
	input  logic     push_i,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output payload_t head_o,		// oldest entry, combinational
	output logic     empty_o,
	output logic     full_o
);

	localparam int aw = $clog2(DEPTH);

	payload_t      mem [DEPTH];
	logic [aw:0]   wr_ptr;		// extra msb tells full from empty
	logic [aw:0]   rd_ptr;
	logic          push_ok;
	logic          pop_ok;

	// push while full and pop while empty are dropped
	assign push_ok = push_i & ~full_o;
	assign pop_ok  = pop_i & ~empty_o;

	////////////////////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge CLK40)
	begin
		if (push_ok)
			mem[wr_ptr[aw-1:0]] <= push_data_i;
	end

	assign head_o  = mem[rd_ptr[aw-1:0]];
	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o  = (wr_ptr[aw] != rd_ptr[aw]) &&
		(wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);	// wrapped once

endmodule

// File: source/sem_bus_pkg.sv
// host side: Wishbone widths and register map
package sem_bus_pkg;

	localparam int wb_adr_w = 4;	// word address
	localparam int wb_dat_w = 32;

	// register addresses
	typedef enum logic [wb_adr_w-1:0] {
		reg_status = 4'd0, reg_ctrl, reg_txdata, reg_cmd, reg_counts, reg_clear, reg_evfar, reg_evsyn
	} sem_reg_e;

	////////////////////////////////////////////////////////////////////////////
	// bit positions inside the registers
	////////////////////////////////////////////////////////////////////////////

	// STATUS, bits 7:0 carry the core flags
	localparam int st_eccerr_b    = 8;
	localparam int st_eccsingle_b = 9;
	localparam int st_cmdbusy_b   = 10;
	localparam int st_txempty_b   = 11;
	localparam int st_evempty_b   = 12;
	localparam int st_evovf_b     = 13;

	localparam int ctrl_hold_b      = 0;	// CTRL hold enable
	localparam int txdata_valid_b   = 8;	// TXDATA, byte below it
	localparam int counts_multi_lsb = 8;	// COUNTS, single count at 0
	localparam int evsyn_bit_lsb    = 7;	// EVSYN, synword at 0
	localparam int evsyn_valid_b    = 31;

endpackage

// File: source/sem_cfg_pkg.sv
// what the SEM core and frame ECC side look like to the monitor
package sem_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// field widths of the frame ECC outputs
	////////////////////////////////////////////////////////////////////////////

	localparam int sem_far_w = 24, sem_synword_w = 7, sem_synbit_w = 5;

	localparam int sem_cnt_w = 8;	// error counters, saturate at all ones

	// bit positions of the eight core status flags in status_i
	typedef enum int unsigned {
		sem_st_heartbeat = 0, sem_st_initialization, sem_st_observation, sem_st_correction,
		sem_st_classification, sem_st_injection, sem_st_essential, sem_st_uncorrectable
	} sem_status_e;

	////////////////////////////////////////////////////////////////////////////
	// one syndrome event as stored in the event FIFO
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [sem_far_w-1:0]     far;		// frame address
		logic [sem_synword_w-1:0] synword;	// word inside the frame
		logic [sem_synbit_w-1:0]  synbit;	// bit inside the word
	} sem_ecc_event_t;	// 36 bits

endpackage
